/* mipsCtrl.f */
design/mipsCtrlPkg.sv
design/opDecoder.sv
design/cycleSequencer.sv
design/controlEncoder.sv
design/ctrlUnit.sv
verification/ctrlUnit_props.sv
verification/ctrlUnitTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --assert --timing --timescale 1ns/1ps -j 0
TOP       = ctrlUnitTb
FILELIST  = mipsCtrl.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

/* verification/ctrlUnitTb.sv */
`timescale 1ns/1ps

module ctrlUnitTb;

    import mipsCtrlPkg::*;

    localparam int fetchWait  = 3;
    localparam int fetchSteps = fetchWait + 1;  // Wait steps plus the PC write
    localparam int waitLimit  = 40;
    localparam logic [5:0] opLoadWord = 6'b100011;  // lw, not decoded
    localparam logic [5:0] functMult  = 6'b011000;  // mult, not decoded

    typedef struct {
        string         name;
        logic [5:0]    opcode;
        logic [5:0]    funct;
        logic          overflow;
        int            latency;
        logic          writes;
        regDstSel_t    regDst;
        writeDataSel_t writeData;
        aluOp_t        aluOp;
        logic          traps;
        trapCause_t    cause;
    } testRow_t;

    logic        clk;
    logic        reset;
    logic [31:0] instruction;
    logic        overflow;
    ctrlWord_t   ctrl;
    trap_t       trap;

    testRow_t    rows[$];
    logic [31:0] rngState = 32'd45799;
    logic        prevWriteInstr = 1'b0;
    logic        sampledWriteInstr = 1'b0;
    logic        timedOut = 1'b0;
    logic        resetOk;
    int          passCount = 0;
    int          failCount = 0;

    ctrlUnit #(
        .fetchWaitCycles(fetchWait)
    ) i_dut (
        .clk        (clk),
        .reset      (reset),
        .instruction(instruction),
        .overflow   (overflow),
        .ctrl       (ctrl),
        .trap       (trap)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] nextRandom(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic void addRow(input string name, input logic [5:0] opcode,
                                   input logic [5:0] funct, input logic ovf, input int latency,
                                   input logic writes, input regDstSel_t regDst,
                                   input writeDataSel_t writeData, input aluOp_t aluOp,
                                   input logic traps, input trapCause_t cause);
        testRow_t row;
        row.name      = name;
        row.opcode    = opcode;
        row.funct     = funct;
        row.overflow  = ovf;
        row.latency   = latency;
        row.writes    = writes;
        row.regDst    = regDst;
        row.writeData = writeData;
        row.aluOp     = aluOp;
        row.traps     = traps;
        row.cause     = cause;
        rows.push_back(row);
    endfunction

    // Outputs are sampled on the falling edge
    task automatic nextCycle();
        prevWriteInstr = sampledWriteInstr;
        @(negedge clk);
        sampledWriteInstr = ctrl.writeInstruction;
    endtask

    function automatic logic fetchStart();
        return sampledWriteInstr && !prevWriteInstr;
    endfunction

    task automatic report(input string name, input logic ok);
        if (ok) begin
            passCount++;
        end else begin
            failCount++;
        end
        $display("%s: %s", name, ok ? "ok" : "FAILED");
    endtask

    task automatic waitForFetch(output logic hung);
        int cycles;
        cycles = 0;
        hung = 1'b0;
        while (!fetchStart() && !hung) begin
            nextCycle();
            cycles++;
            if (cycles > waitLimit) begin
                hung = 1'b1;
            end
        end
    endtask

    task automatic checkReset(output logic ok);
        ok = 1'b1;
        nextCycle();  // Step spent in stReset
        if (!ctrl.writeReg || ctrl.regDst != regDstStackPointer ||
            ctrl.writeData != wdStackTop || ctrl.writePc || trap.raise) begin
            $display("ERR %0t: reset step writeReg %0b regDst %0d writeData %0d", $time,
                     ctrl.writeReg, ctrl.regDst, ctrl.writeData);
            ok = 1'b0;
        end
        nextCycle();
        if (!fetchStart()) begin
            $display("ERR %0t: no fetch after the reset step", $time);
            ok = 1'b0;
        end
    endtask

    task automatic runRow(input testRow_t row, output logic hung);
        int cycles;
        int instrCycles;
        int pcPulses;
        int regPulses;
        int trapPulses;
        int regCycle;
        int trapCycle;
        logic ok;
        aluOp_t prevAluOp;
        aluOp_t seenAluOp;
        regDstSel_t seenRegDst;
        writeDataSel_t seenWriteData;
        trapCause_t seenCause;
        cycles = 0;
        instrCycles = 0;
        pcPulses = 0;
        regPulses = 0;
        trapPulses = 0;
        regCycle = 0;
        trapCycle = 0;
        ok = 1'b1;
        hung = 1'b0;
        prevAluOp = aluAdd;
        seenAluOp = aluAdd;
        seenRegDst = regDstRd;
        seenWriteData = wdAluOut;
        seenCause = causeOverflow;
        rngState = nextRandom(rngState);
        do begin
            cycles++;
            instrCycles += ctrl.writeInstruction ? 1 : 0;
            pcPulses += ctrl.writePc ? 1 : 0;
            if (ctrl.writeReg) begin
                regPulses++;
                regCycle = cycles;
                seenRegDst = ctrl.regDst;
                seenWriteData = ctrl.writeData;
                seenAluOp = prevAluOp;  // ALU op of the step before the write
            end
            if (trap.raise) begin
                trapPulses++;
                trapCycle = cycles;
                seenCause = trap.cause;
            end
            prevAluOp = ctrl.aluOp;
            if (cycles == 1) begin
                @(posedge clk);
                if (row.opcode == opRType) begin
                    instruction <= {row.opcode, rngState[25:6], row.funct};
                end else begin
                    instruction <= {row.opcode, rngState[25:0]};  // Random funct bits
                end
                overflow <= row.overflow;
            end
            nextCycle();
            hung = (cycles >= waitLimit);
        end while (!fetchStart() && !hung);
        if (hung) begin
            $display("%s timed out: the next fetch never started", row.name);
            ok = 1'b0;
        end else begin
            if (cycles != row.latency) begin
                $display("ERR %0t: %s latency %0d, expected %0d", $time, row.name,
                         cycles, row.latency);
                ok = 1'b0;
            end
            if (instrCycles != fetchWait || pcPulses != 1) begin
                $display("ERR %0t: %s fetch had %0d instruction steps and %0d PC writes",
                         $time, row.name, instrCycles, pcPulses);
                ok = 1'b0;
            end
            if (regPulses != (row.writes ? 1 : 0)) begin
                $display("ERR %0t: %s wrote the register file %0d times", $time, row.name,
                         regPulses);
                ok = 1'b0;
            end else if (row.writes && (seenRegDst != row.regDst ||
                         seenWriteData != row.writeData || seenAluOp != row.aluOp)) begin
                $display("ERR %0t: %s write regDst %0d writeData %0d aluOp %0d", $time,
                         row.name, seenRegDst, seenWriteData, seenAluOp);
                ok = 1'b0;
            end
            if (trapPulses != (row.traps ? 1 : 0) || (row.traps && seenCause != row.cause)) begin
                $display("ERR %0t: %s raised %0d traps, cause %0d", $time, row.name,
                         trapPulses, seenCause);
                ok = 1'b0;
            end
            if (row.writes && row.traps && trapCycle != regCycle + 1) begin
                $display("ERR %0t: %s trap not right after the write", $time, row.name);
                ok = 1'b0;
            end
        end
        report(row.name, ok);
    endtask

    initial begin
        reset = 1'b1;
        instruction = '0;
        overflow = 1'b0;

        addRow("add", opRType, functAdd, 1'b0, fetchSteps + 4,
               1'b1, regDstRd, wdAluOut, aluAdd, 1'b0, causeOverflow);
        addRow("and", opRType, functAnd, 1'b0, fetchSteps + 4,
               1'b1, regDstRd, wdAluOut, aluAnd, 1'b0, causeOverflow);
        addRow("sub", opRType, functSub, 1'b0, fetchSteps + 4,
               1'b1, regDstRd, wdAluOut, aluSub, 1'b0, causeOverflow);
        addRow("addi", opAddi, 6'd0, 1'b0, fetchSteps + 4,
               1'b1, regDstRt, wdAluOut, aluAdd, 1'b0, causeOverflow);
        addRow("addiu", opAddiu, 6'd0, 1'b0, fetchSteps + 4,
               1'b1, regDstRt, wdAluOut, aluAdd, 1'b0, causeOverflow);
        addRow("sll", opRType, functSll, 1'b0, fetchSteps + 5,
               1'b1, regDstRd, wdShiftReg, aluShift, 1'b0, causeOverflow);
        addRow("add overflow", opRType, functAdd, 1'b1, fetchSteps + 5,
               1'b1, regDstRd, wdAluOut, aluAdd, 1'b1, causeOverflow);
        addRow("addi overflow", opAddi, 6'd0, 1'b1, fetchSteps + 4,
               1'b0, regDstRd, wdAluOut, aluAdd, 1'b1, causeOverflow);
        addRow("addiu overflow", opAddiu, 6'd0, 1'b1, fetchSteps + 4,
               1'b1, regDstRt, wdAluOut, aluAdd, 1'b0, causeOverflow);
        addRow("bad opcode", opLoadWord, 6'd0, 1'b0, fetchSteps + 3,
               1'b0, regDstRd, wdAluOut, aluAdd, 1'b1, causeBadOpcode);
        addRow("bad funct", opRType, functMult, 1'b0, fetchSteps + 3,
               1'b0, regDstRd, wdAluOut, aluAdd, 1'b1, causeBadOpcode);

        repeat (3) @(posedge clk);
        reset <= 1'b0;
        checkReset(resetOk);
        report("reset", resetOk);

        for (int i = 0; i < rows.size() && !timedOut; i++) begin
            waitForFetch(timedOut);
            if (timedOut) begin
                $display("%s timed out: fetch never started", rows[i].name);
            end else begin
                runRow(rows[i], timedOut);
            end
        end

        $display("%0d tests passed, %0d failed", passCount, failCount);
        if (failCount == 0 && !timedOut) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* verification/ctrlUnit_props.sv */
`timescale 1ns/1ps

module ctrlUnitProps (
    input logic                   clk,
    input logic                   reset,
    input mipsCtrlPkg::ctrlWord_t ctrl,
    input mipsCtrlPkg::trap_t     trap
);

    // Fetch and register write are separate steps
    noFetchDuringWrite: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.writeInstruction && ctrl.writeReg))
        else $error("writeInstruction and writeReg active together");

    trapOneCycle: assert property (@(posedge clk) disable iff (reset)
        trap.raise |=> !trap.raise && ctrl.writeInstruction)
        else $error("trap pulse not a single cycle followed by fetch");

    noPcWriteAfterReset: assert property (@(posedge clk) $fell(reset) |-> !ctrl.writePc)
        else $error("writePc active in the first cycle after reset");

endmodule

bind ctrlUnit ctrlUnitProps i_props (
    .clk  (clk),
    .reset(reset),
    .ctrl (ctrl),
    .trap (trap)
);

/* design/ctrlUnit.sv */
`timescale 1ns/1ps

module ctrlUnit #(
    parameter int fetchWaitCycles = 3
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [31:0]            instruction,
    input  logic                   overflow,
    output mipsCtrlPkg::ctrlWord_t ctrl,
    output mipsCtrlPkg::trap_t     trap
);

    import mipsCtrlPkg::*;

    ctrlState_t execState;
    ctrlState_t state;
    stepCount_t step;
    logic       lastFetchStep;

    opDecoder i_opDecoder (
        .opcode   (instruction[31:26]),
        .funct    (instruction[5:0]),  // Low bits of the immediate for I-type
        .execState(execState)
    );

    cycleSequencer #(
        .fetchWaitCycles(fetchWaitCycles)
    ) i_cycleSequencer (
        .clk          (clk),
        .reset        (reset),
        .execState    (execState),
        .overflow     (overflow),
        .state        (state),
        .step         (step),
        .lastFetchStep(lastFetchStep)
    );

    controlEncoder i_controlEncoder (
        .state        (state),
        .step         (step),
        .lastFetchStep(lastFetchStep),
        .ctrl         (ctrl),
        .trap         (trap)
    );

endmodule

/* design/controlEncoder.sv */
`timescale 1ns/1ps

module controlEncoder (
    input  mipsCtrlPkg::ctrlState_t state,
    input  mipsCtrlPkg::stepCount_t step,
    input  logic                    lastFetchStep,
    output mipsCtrlPkg::ctrlWord_t  ctrl,
    output mipsCtrlPkg::trap_t      trap
);

    import mipsCtrlPkg::*;

    always_comb begin
        ctrl       = ctrlIdle;
        trap.raise = 1'b0;
        trap.cause = causeOverflow;

        case (state)
            stReset: begin
                // Load the stack pointer register
                ctrl.writeReg  = 1'b1;
                ctrl.regDst    = regDstStackPointer;
                ctrl.writeData = wdStackTop;
            end
            stFetch: begin
                if (lastFetchStep) begin
                    ctrl.writePc = 1'b1;
                    ctrl.pcSrc   = pcSrcAluOut;  // PC + 4 held in ALUOut
                end else begin
                    ctrl.writeInstruction = 1'b1;
                    ctrl.writeAluOut      = 1'b1;
                    ctrl.memAddr          = memAddrPc;
                    ctrl.aluSrcA          = aSrcPc;
                    ctrl.aluSrcB          = bSrcFour;
                    ctrl.aluOp            = aluAdd;
                end
            end
            stPrecalc: begin
                ctrl.writeAluOut = 1'b1;  // Branch target
                ctrl.aluSrcB     = bSrcBranchOffset;
            end
            stDecode: begin
                ctrl.writeA = 1'b1;
                ctrl.writeB = 1'b1;
            end
            stAdd, stAnd, stSub: begin
                ctrl.writeAluOut = 1'b1;
                ctrl.aluSrcA     = aSrcRegA;
                ctrl.aluSrcB     = bSrcRegB;
                case (state)
                    stAnd: begin
                        ctrl.aluOp = aluAnd;
                    end
                    stSub: begin
                        ctrl.aluOp = aluSub;
                    end
                    default: begin
                        ctrl.aluOp = aluAdd;
                    end
                endcase
            end
            stSaveResult: begin
                ctrl.writeReg  = 1'b1;
                ctrl.regDst    = regDstRd;
                ctrl.writeData = wdAluOut;
            end
            stAddi, stAddiu: begin
                ctrl.writeAluOut = 1'b1;
                ctrl.aluSrcA     = aSrcRegA;
                ctrl.aluSrcB     = bSrcImmediate;
                ctrl.aluOp       = aluAdd;
            end
            stWriteImm: begin
                ctrl.writeReg  = 1'b1;
                ctrl.regDst    = regDstRt;
                ctrl.writeData = wdAluOut;
            end
            stSll: begin
                ctrl.aluOp       = aluShift;
                ctrl.shiftAmount = shamtField;
                if (step == '0) begin
                    ctrl.shiftOp = shiftLoad;  // Capture rt into the shifter
                end else begin
                    ctrl.shiftOp = shiftLeft;
                end
                if (step == sllLastStep) begin
                    ctrl.writeReg  = 1'b1;
                    ctrl.regDst    = regDstRd;
                    ctrl.writeData = wdShiftReg;
                end
            end
            stOverflow: begin
                trap.raise = 1'b1;
                trap.cause = causeOverflow;
            end
            stBadOpcode: begin
                trap.raise = 1'b1;
                trap.cause = causeBadOpcode;
            end
            default: begin
                ctrl = ctrlIdle;
            end
        endcase
    end

endmodule

/* design/cycleSequencer.sv */
`timescale 1ns/1ps

module cycleSequencer #(
    parameter int fetchWaitCycles = 3
) (
    input  logic                    clk,
    input  logic                    reset,
    input  mipsCtrlPkg::ctrlState_t execState,
    input  logic                    overflow,
    output mipsCtrlPkg::ctrlState_t state,
    output mipsCtrlPkg::stepCount_t step,
    output logic                    lastFetchStep
);

    import mipsCtrlPkg::*;

    localparam stepCount_t fetchLastStep = stepCount_t'(fetchWaitCycles);

    ctrlState_t stateNext;
    stepCount_t stepNext;

    if (fetchWaitCycles < 1 || fetchWaitCycles > FETCH_WAIT_MAX) begin : gBadWait
        $error("fetchWaitCycles must lie in 1..FETCH_WAIT_MAX");
    end

    always_comb begin
        stateNext = state;
        stepNext  = '0;  // New states start at step 0
        case (state)
            stReset: begin
                stateNext = stFetch;
            end
            stFetch: begin
                if (lastFetchStep) begin
                    stateNext = stPrecalc;
                end else begin
                    stepNext = step + 1'b1;  // Still waiting on memory
                end
            end
            stPrecalc: begin
                stateNext = stDecode;
            end
            stDecode: begin
                stateNext = execState;
            end
            stAdd, stAnd, stSub: begin
                stateNext = stSaveResult;
            end
            stSaveResult: begin
                // Result is already written when the trap is taken
                stateNext = overflow ? stOverflow : stFetch;
            end
            stAddi: begin
                stateNext = overflow ? stOverflow : stWriteImm;
            end
            stAddiu: begin
                stateNext = stWriteImm;
            end
            stSll: begin
                if (step == sllLastStep) begin
                    stateNext = stFetch;
                end else begin
                    stepNext = step + 1'b1;
                end
            end
            default: begin
                stateNext = stFetch;  // stWriteImm and both traps
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= stReset;
            step          <= '0;
            lastFetchStep <= 1'b0;
        end else begin
            state         <= stateNext;
            step          <= stepNext;
            // Flag the PC write step one cycle ahead
            lastFetchStep <= (stateNext == stFetch) && (stepNext == fetchLastStep);
        end
    end

endmodule

/* design/opDecoder.sv */
`timescale 1ns/1ps

module opDecoder (
    input  logic [5:0]              opcode,
    input  logic [5:0]              funct,
    output mipsCtrlPkg::ctrlState_t execState
);

    import mipsCtrlPkg::*;

    always_comb begin
        execState = stBadOpcode;
        case (opcode)
            opRType: begin
                // Only the funct field tells R-type ops apart
                case (funct)
                    functAdd: begin
                        execState = stAdd;
                    end
                    functAnd: begin
                        execState = stAnd;
                    end
                    functSub: begin
                        execState = stSub;
                    end
                    functSll: begin
                        execState = stSll;
                    end
                    default: begin
                        execState = stBadOpcode;  // Unsupported funct
                    end
                endcase
            end
            opAddi: begin
                execState = stAddi;
            end
            opAddiu: begin
                execState = stAddiu;
            end
            default: begin
                execState = stBadOpcode;
            end
        endcase
    end

endmodule

/* design/mipsCtrlPkg.sv */
package mipsCtrlPkg;

    // Upper bound for the fetch wait parameter
    localparam int FETCH_WAIT_MAX = 6;

    // Opcodes
    localparam logic [5:0] opRType = 6'b000000;
    localparam logic [5:0] opAddi  = 6'b001000;
    localparam logic [5:0] opAddiu = 6'b001001;

    // R-type funct codes
    localparam logic [5:0] functAdd = 6'b100000;
    localparam logic [5:0] functAnd = 6'b100100;
    localparam logic [5:0] functSub = 6'b100010;
    localparam logic [5:0] functSll = 6'b000000;

    typedef enum logic [2:0] {aluAdd = 3'd1, aluSub = 3'd2, aluAnd = 3'd3, aluShift = 3'd4} aluOp_t;
    typedef enum logic [2:0] {memAddrPc = 3'd2} memAddrSel_t;
    typedef enum logic [1:0] {aSrcPc = 2'd0, aSrcRegA = 2'd1} aluSrcASel_t;
    typedef enum logic [2:0] {
        bSrcRegB         = 3'd0,
        bSrcFour         = 3'd1,
        bSrcBranchOffset = 3'd2,
        bSrcImmediate    = 3'd3
    } aluSrcBSel_t;
    typedef enum logic [1:0] {pcSrcAluResult = 2'd0, pcSrcAluOut = 2'd2} pcSrcSel_t;
    typedef enum logic [1:0] {regDstRd = 2'd0, regDstStackPointer = 2'd1, regDstRt = 2'd3} regDstSel_t;
    typedef enum logic [2:0] {wdAluOut = 3'd0, wdStackTop = 3'd3, wdShiftReg = 3'd6} writeDataSel_t;
    typedef enum logic [2:0] {shiftNone = 3'd0, shiftLoad = 3'd1, shiftLeft = 3'd2} shiftOp_t;
    typedef enum logic [1:0] {shamtNone = 2'd0, shamtField = 2'd2} shiftAmountSel_t;

    // Sparse state codes
    typedef enum logic [5:0] {
        stReset      = 6'd1,
        stFetch      = 6'd2,
        stPrecalc    = 6'd5,
        stDecode     = 6'd6,
        stAdd        = 6'd7,
        stAnd        = 6'd8,
        stSub        = 6'd9,
        stSaveResult = 6'd10,
        stSll        = 6'd15,
        stAddiu      = 6'd39,
        stAddi       = 6'd40,
        stWriteImm   = 6'd41,
        stBadOpcode  = 6'd43,
        stOverflow   = 6'd44
    } ctrlState_t;

    typedef logic [2:0] stepCount_t;

    localparam stepCount_t sllLastStep = 3'd2;  // Load, shift, shift+write

    typedef struct packed {
        logic            writePc;
        logic            writeA;
        logic            writeB;
        logic            writeAluOut;
        logic            writeMem;
        logic            writeInstruction;
        logic            writeReg;
        memAddrSel_t     memAddr;
        aluSrcASel_t     aluSrcA;
        aluSrcBSel_t     aluSrcB;
        pcSrcSel_t       pcSrc;
        regDstSel_t      regDst;
        writeDataSel_t   writeData;
        aluOp_t          aluOp;
        shiftOp_t        shiftOp;
        shiftAmountSel_t shiftAmount;
        logic            shiftSrc;
    } ctrlWord_t;

    typedef enum logic {causeOverflow = 1'b0, causeBadOpcode = 1'b1} trapCause_t;

    typedef struct packed {
        logic       raise;
        trapCause_t cause;
    } trap_t;

    // Nothing written, muxes parked
    localparam ctrlWord_t ctrlIdle = '{
        writePc: 1'b0, writeA: 1'b0, writeB: 1'b0, writeAluOut: 1'b0,
        writeMem: 1'b0, writeInstruction: 1'b0, writeReg: 1'b0,
        memAddr: memAddrPc, aluSrcA: aSrcPc, aluSrcB: bSrcRegB,
        pcSrc: pcSrcAluOut, regDst: regDstRd, writeData: wdAluOut,
        aluOp: aluAdd, shiftOp: shiftNone, shiftAmount: shamtNone,
        shiftSrc: 1'b0
    };

endpackage
